//--- tests/rider_testdata.txt
# left right hold ctrl | rider_off steer_out status events clear_mask (hex, hold decimal)
# events is read before clear_mask is written back to EVENTS
000 000 16   0 1 0 2 0 0
180 180 1200 0 0 0 9 1 1
180 180 16   1 0 1 9 0 0
300 000 40   1 0 0 4 4 4
200 100 1300 1 0 0 4 0 0
180 180 1200 1 0 1 9 0 0
100 100 40   1 0 1 9 0 0
0c0 0c0 40   1 1 0 2 6 2
100 100 40   1 1 0 2 4 4
180 180 1200 0 0 0 9 1 7
000 000 40   0 1 0 2 6 7

//--- all.f
+incdir+.
source/seg_load_pkg.sv
source/seg_apb_pkg.sv
source/load_cell_avg.sv
source/steer_en.sv
source/steer_apb_regs.sv
source/rider_detect_top.sv
tests/rider_detect_chk.sv
tests/rider_detect_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rider detect testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module rider_detect_tb -f all.f; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/Vrider_detect_tb)"
sim_rc=$?
echo "$sim_out"

if [ "$sim_rc" -ne 0 ]; then
  echo "simulation exited with status $sim_rc"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

//--- tests/rider_detect_tb.sv
`timescale 1ns/1ns
`include "seg_defines.svh"

module rider_detect_tb;

  // cycles an apb access may wait for pready
  localparam int apb_timeout = 16;

  logic clk;
  logic rst_n;
  logic ld_vld;
  seg_load_pkg::load_t lft_raw;
  seg_load_pkg::load_t rght_raw;
  logic psel;
  logic penable;
  logic pwrite;
  seg_apb_pkg::apb_addr_t paddr;
  seg_apb_pkg::apb_data_t pwdata;
  seg_apb_pkg::apb_data_t prdata;
  logic pready;
  logic steer_out;
  logic rider_off;

  int checks;
  int errors;

  rider_detect_top #(.fast_sim(1'b1)) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .ld_vld    (ld_vld),
    .lft_raw   (lft_raw),
    .rght_raw  (rght_raw),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .steer_out (steer_out),
    .rider_off (rider_off)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // closing count line and the verdict
  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  // setup cycle then access cycle until pready
  task automatic apb_xfer(input logic wr, input seg_apb_pkg::apb_addr_t addr,
                          input seg_apb_pkg::apb_data_t wdata,
                          output seg_apb_pkg::apb_data_t rdata);
    int waited;
    waited  = 0;
    rdata   = '0;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;
    // read data sampled mid-cycle
    @(negedge clk);
    while (pready !== 1'b1 && waited < apb_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (pready !== 1'b1) begin
      $display("APB access to address %0h timed out waiting for pready", addr);
      errors++;
      finish_run();
    end else begin
      rdata = prdata;
      // write lands on this edge
      next_cycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
    end
  endtask

  task automatic read_check(input string name, input seg_apb_pkg::apb_addr_t addr,
                            input seg_apb_pkg::apb_data_t exp);
    seg_apb_pkg::apb_data_t rdata;
    apb_xfer(1'b0, addr, 32'd0, rdata);
    check_value(name, rdata, exp);
  endtask

  // one data file line
  task automatic run_step(input seg_load_pkg::load_t lft, input seg_load_pkg::load_t rght,
                          input int hold, input logic allow, input logic exp_off,
                          input logic exp_out, input logic [3:0] exp_status,
                          input seg_apb_pkg::evt_vec_t exp_evt,
                          input seg_apb_pkg::evt_vec_t clr);
    seg_apb_pkg::apb_data_t rdata;
    apb_xfer(1'b1, `SEG_REG_CTRL, {31'd0, allow}, rdata);
    lft_raw  = lft;
    rght_raw = rght;
    // strobe every fourth cycle
    for (int c = 0; c < hold; c++) begin
      ld_vld = (c % 4 == 0);
      next_cycle();
    end
    ld_vld = 1'b0;
    @(negedge clk);
    check_value("rider_off", 32'(rider_off), 32'(exp_off));
    check_value("steer_out", 32'(steer_out), 32'(exp_out));
    next_cycle();
    read_check("STATUS", `SEG_REG_STATUS, {28'd0, exp_status});
    // four equal samples average to the sample itself
    read_check("LOADS", `SEG_REG_LOADS, {4'd0, rght, 4'd0, lft});
    read_check("CTRL", `SEG_REG_CTRL, {31'd0, allow});
    read_check("EVENTS", `SEG_REG_EVENTS, {29'd0, exp_evt});
    apb_xfer(1'b1, `SEG_REG_EVENTS, {29'd0, clr}, rdata);
    // write one to clear leaves the rest
    read_check("EVENTS after clear", `SEG_REG_EVENTS, {29'd0, exp_evt & ~clr});
  endtask

  initial begin
    int fd;
    int n_fields;
    int steps;
    string line;
    seg_load_pkg::load_t lft;
    seg_load_pkg::load_t rght;
    int hold;
    logic allow;
    logic exp_off;
    logic exp_out;
    logic [3:0] exp_status;
    seg_apb_pkg::evt_vec_t exp_evt;
    seg_apb_pkg::evt_vec_t clr;
    seg_apb_pkg::apb_data_t rdata;
    checks   = 0;
    errors   = 0;
    steps    = 0;
    rst_n    = 1'b0;
    ld_vld   = 1'b0;
    lft_raw  = '0;
    rght_raw = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    repeat (8) next_cycle();
    rst_n = 1'b1;
    next_cycle();
    // unmapped space reads zero and drops writes
    read_check("unmapped read", 8'h10, 32'd0);
    // 0x1c matches CTRL in its low address bits
    apb_xfer(1'b1, 8'h1C, 32'hffff_ffff, rdata);
    read_check("CTRL after unmapped write", `SEG_REG_CTRL, 32'd0);
    fd = $fopen("tests/rider_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/rider_testdata.txt");
      errors++;
      finish_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        // comment and blank lines do not parse
        n_fields = $sscanf(line, "%h %h %d %h %h %h %h %h %h", lft, rght, hold, allow,
                           exp_off, exp_out, exp_status, exp_evt, clr);
        if (n_fields == 9) begin
          run_step(lft, rght, hold, allow, exp_off, exp_out, exp_status, exp_evt, clr);
          steps++;
        end
      end
      $fclose(fd);
      if (steps == 0) begin
        $display("no test steps found in tests/rider_testdata.txt");
        errors++;
      end
      finish_run();
    end
  end

endmodule

//--- tests/rider_detect_chk.sv
`timescale 1ns/1ns

module rider_detect_chk #(
  parameter bit has_apb = 1'b0
) (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       en_steer,
  input logic                       rider_off,
  input seg_load_pkg::steer_state_t state,
  input logic                       pready
);

  // steering and rider gone exclude each other
  flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(en_steer && rider_off))
    else $error("en_steer and rider_off high in the same cycle");

  // 2'b11 is the unused encoding
  state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    2'(state) != 2'b11)
    else $error("steering state holds the unused encoding");

  // zero wait state slave
  if (has_apb) begin : g_apb
    pready_high: assert property (@(posedge clk) disable iff (!rst_n)
      pready == 1'b1)
      else $error("pready went low");
  end

endmodule

bind steer_en rider_detect_chk #(.has_apb(1'b0)) u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .en_steer  (en_steer),
  .rider_off (rider_off),
  .state     (state),
  .pready    (1'b1)
);

bind steer_apb_regs rider_detect_chk #(.has_apb(1'b1)) u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .en_steer  (en_steer),
  .rider_off (rider_off),
  .state     (state),
  .pready    (pready)
);

//--- source/rider_detect_top.sv
`timescale 1ns/1ns

module rider_detect_top #(
  parameter bit fast_sim = 1'b1
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ld_vld,
  input  seg_load_pkg::load_t    lft_raw,
  input  seg_load_pkg::load_t    rght_raw,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  seg_apb_pkg::apb_addr_t paddr,
  input  seg_apb_pkg::apb_data_t pwdata,
  output seg_apb_pkg::apb_data_t prdata,
  output logic                   pready,
  output logic                   steer_out,
  output logic                   rider_off
);

  // filtered loads
  seg_load_pkg::load_t lft_ld;
  seg_load_pkg::load_t rght_ld;
  // decision outputs
  logic en_steer;
  seg_load_pkg::steer_state_t state;

  // four-sample smoothing
  load_cell_avg u_avg (
    .clk      (clk),
    .rst_n    (rst_n),
    .ld_vld   (ld_vld),
    .lft_raw  (lft_raw),
    .rght_raw (rght_raw),
    .lft_ld   (lft_ld),
    .rght_ld  (rght_ld)
  );

  // rider presence and steady stance
  steer_en #(.fast_sim(fast_sim)) u_steer (
    .clk       (clk),
    .rst_n     (rst_n),
    .lft_ld    (lft_ld),
    .rght_ld   (rght_ld),
    .en_steer  (en_steer),
    .rider_off (rider_off),
    .state     (state)
  );

  // host view, sticky events, steering gate
  steer_apb_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .en_steer  (en_steer),
    .rider_off (rider_off),
    .state     (state),
    .lft_ld    (lft_ld),
    .rght_ld   (rght_ld),
    .steer_out (steer_out)
  );

endmodule

//--- source/steer_apb_regs.sv
`timescale 1ns/1ns
`include "seg_defines.svh"

module steer_apb_regs (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  seg_apb_pkg::apb_addr_t     paddr,
  input  seg_apb_pkg::apb_data_t     pwdata,
  output seg_apb_pkg::apb_data_t     prdata,
  output logic                       pready,
  input  logic                       en_steer,
  input  logic                       rider_off,
  input  seg_load_pkg::steer_state_t state,
  input  seg_load_pkg::load_t        lft_ld,
  input  seg_load_pkg::load_t        rght_ld,
  output logic                       steer_out
);

  logic en_steer_d;
  logic rider_off_d;
  logic steer_allow;
  logic wr_en;
  logic rd_en;
  seg_apb_pkg::evt_vec_t evt;
  seg_apb_pkg::evt_vec_t evt_set;
  seg_apb_pkg::evt_vec_t evt_clr;

  // zero wait states
  assign pready = 1'b1;

  // access phase only
  assign wr_en = psel & penable & pwrite;
  assign rd_en = psel & penable & ~pwrite;

  // flag edges from last cycle's copy
  always_comb begin
    evt_set = '0;
    evt_set[seg_apb_pkg::evt_rider_on]   = rider_off_d & ~rider_off;
    evt_set[seg_apb_pkg::evt_rider_off]  = ~rider_off_d & rider_off;
    evt_set[seg_apb_pkg::evt_steer_lost] = en_steer_d & ~en_steer;
  end

  // write one to clear
  assign evt_clr = (wr_en && paddr == `SEG_REG_EVENTS) ?
                   pwdata[seg_apb_pkg::evt_num-1:0] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_steer_d  <= 1'b0;
      // reset state already reports rider_off
      rider_off_d <= 1'b1;
      evt         <= '0;
      steer_allow <= 1'b0;
    end else begin
      en_steer_d  <= en_steer;
      rider_off_d <= rider_off;
      // a set in the same cycle beats the clear
      evt <= (evt & ~evt_clr) | evt_set;
      if (wr_en && paddr == `SEG_REG_CTRL) begin
        steer_allow <= pwdata[0];
      end
    end
  end

  // read mux, unmapped reads zero
  always_comb begin
    prdata = '0;
    if (rd_en) begin
      case (paddr)
        `SEG_REG_STATUS: prdata = {28'd0, 2'(state), rider_off, en_steer};
        `SEG_REG_LOADS:  prdata = {4'd0, rght_ld, 4'd0, lft_ld};
        `SEG_REG_EVENTS: prdata = {{(32 - seg_apb_pkg::evt_num){1'b0}}, evt};
        `SEG_REG_CTRL:   prdata = {31'd0, steer_allow};
        default:         prdata = '0;
      endcase
    end
  end

  // host gate on the steering enable
  assign steer_out = en_steer & steer_allow;

endmodule

//--- source/steer_en.sv
`timescale 1ns/1ns
`include "seg_defines.svh"

module steer_en #(
  parameter bit fast_sim = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  seg_load_pkg::load_t        lft_ld,
  input  seg_load_pkg::load_t        rght_ld,
  output logic                       en_steer,
  output logic                       rider_off,
  output seg_load_pkg::steer_state_t state
);

  // weight limits with hysteresis
  localparam seg_load_pkg::load_sum_t lo_lim = `SEG_MIN_RIDER_WT - `SEG_WT_HYST;
  localparam seg_load_pkg::load_sum_t hi_lim = `SEG_MIN_RIDER_WT + `SEG_WT_HYST;

  seg_load_pkg::load_sum_t ld_sum;
  seg_load_pkg::load_sum_t sum_qtr;
  seg_load_pkg::load_sum_t sum_1516;
  seg_load_pkg::load_t diff_abs;
  seg_load_pkg::steady_tmr_t tmr;
  seg_load_pkg::steer_state_t next_state;

  // fsm inputs
  logic tmr_full;
  logic sum_lt_min;
  logic sum_gt_min;
  logic diff_gt_qtr;
  logic diff_gt_1516;
  // fsm output
  logic clr_tmr;

  assign ld_sum = seg_load_pkg::load_sum_t'(lft_ld) + seg_load_pkg::load_sum_t'(rght_ld);
  // unsigned magnitude, no sign bit needed
  assign diff_abs = (lft_ld > rght_ld) ? (lft_ld - rght_ld) : (rght_ld - lft_ld);
  assign sum_qtr  = ld_sum >> 2;
  // 511 x 15 still fits in 13 bits
  assign sum_1516 = (ld_sum >> 4) * 13'd15;

  assign sum_lt_min   = ld_sum < lo_lim;
  assign sum_gt_min   = ld_sum > hi_lim;
  assign diff_gt_qtr  = 13'(diff_abs) > sum_qtr;
  assign diff_gt_1516 = 13'(diff_abs) > sum_1516;

  // free running, wraps if never cleared
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tmr <= '0;
    end else if (clr_tmr) begin
      tmr <= '0;
    end else begin
      tmr <= tmr + 1'b1;
    end
  end

  // short count in sim, full count on silicon
  generate
    if (fast_sim) begin : g_fast_tmr
      assign tmr_full = &tmr[`SEG_FAST_TMR_W-1:0];
    end else begin : g_full_tmr
      assign tmr_full = &tmr[`SEG_FULL_TMR_W-1:0];
    end
  endgenerate

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= seg_load_pkg::wait_rider;
    end else begin
      state <= next_state;
    end
  end

  // next state and flags, flags decode straight from state
  always_comb begin
    clr_tmr    = 1'b0;
    en_steer   = 1'b0;
    rider_off  = 1'b0;
    next_state = state;
    case (state)
      seg_load_pkg::wait_rider: begin
        if (sum_gt_min) begin
          // rider arrived, start timing
          clr_tmr    = 1'b1;
          next_state = seg_load_pkg::check_steady;
        end else begin
          rider_off = 1'b1;
        end
      end
      seg_load_pkg::check_steady: begin
        if (sum_lt_min) begin
          rider_off  = 1'b1;
          next_state = seg_load_pkg::wait_rider;
        end else if (diff_gt_qtr) begin
          // leaning, restart the count
          clr_tmr = 1'b1;
        end else if (tmr_full) begin
          en_steer   = 1'b1;
          next_state = seg_load_pkg::steering;
        end
      end
      seg_load_pkg::steering: begin
        if (sum_lt_min) begin
          rider_off  = 1'b1;
          next_state = seg_load_pkg::wait_rider;
        end else if (diff_gt_1516) begin
          // nearly one foot off, back to checking
          clr_tmr    = 1'b1;
          next_state = seg_load_pkg::check_steady;
        end else begin
          en_steer = 1'b1;
        end
      end
      default: begin
        next_state = seg_load_pkg::wait_rider;
      end
    endcase
  end

endmodule

//--- source/load_cell_avg.sv
`timescale 1ns/1ns

module load_cell_avg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ld_vld,
  input  seg_load_pkg::load_t lft_raw,
  input  seg_load_pkg::load_t rght_raw,
  output seg_load_pkg::load_t lft_ld,
  output seg_load_pkg::load_t rght_ld
);

  // side 0 is left, side 1 is right
  seg_load_pkg::load_t raw [2];
  // newest sample at index 0
  seg_load_pkg::load_t hist [2][4];
  // sum of the four held samples, 4 x 4095 fits
  logic [13:0] run_sum [2];
  logic [13:0] nxt_sum [2];

  assign raw[0] = lft_raw;
  assign raw[1] = rght_raw;

  // add newest, drop oldest
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      nxt_sum[s] = run_sum[s] + 14'(raw[s]) - 14'(hist[s][3]);
    end
  end

  // history and sum only move on the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < 2; s++) begin
        run_sum[s] <= '0;
        for (int k = 0; k < 4; k++) begin
          hist[s][k] <= '0;
        end
      end
    end else if (ld_vld) begin
      for (int s = 0; s < 2; s++) begin
        hist[s][0] <= raw[s];
        for (int k = 1; k < 4; k++) begin
          hist[s][k] <= hist[s][k-1];
        end
        run_sum[s] <= nxt_sum[s];
      end
    end
  end

  // divide by four, one cycle after the strobe
  assign lft_ld  = run_sum[0][13:2];
  assign rght_ld = run_sum[1][13:2];

endmodule

//--- source/seg_apb_pkg.sv
package seg_apb_pkg;

  // apb byte address
  typedef logic [7:0] apb_addr_t;

  // apb data word
  typedef logic [31:0] apb_data_t;

  // number of sticky event bits
  localparam int unsigned evt_num = 3;

  // sticky event positions in EVENTS
  // rider stepped on, rider_off fell
  localparam int unsigned evt_rider_on = 0;

  // rider stepped off, rider_off rose
  localparam int unsigned evt_rider_off = 1;

  // steering dropped, en_steer fell
  localparam int unsigned evt_steer_lost = 2;

  // vector type for the sticky bits
  typedef logic [evt_num-1:0] evt_vec_t;

endpackage

//--- source/seg_load_pkg.sv
`include "seg_defines.svh"

package seg_load_pkg;

  // one load-cell reading, unsigned
  typedef logic [11:0] load_t;

  // left plus right, one bit of headroom
  typedef logic [12:0] load_sum_t;

  // steady timer, fast mode only looks at the low bits
  typedef logic [`SEG_FULL_TMR_W-1:0] steady_tmr_t;

  // rider decision states
  typedef enum logic [1:0] {
    wait_rider   = 2'b00,
    check_steady = 2'b01,
    steering     = 2'b10
  } steer_state_t;

endpackage

//--- seg_defines.svh
`ifndef SEG_DEFINES_SVH
`define SEG_DEFINES_SVH

// rider weight limit on the summed loads
`define SEG_MIN_RIDER_WT 13'h200
// band on either side of the weight limit
`define SEG_WT_HYST 13'h040

// steady timer widths, sim and silicon
`define SEG_FAST_TMR_W 10
`define SEG_FULL_TMR_W 26

// apb byte offsets
`define SEG_REG_STATUS 8'h00
`define SEG_REG_LOADS 8'h04
`define SEG_REG_EVENTS 8'h08
`define SEG_REG_CTRL 8'h0C

`endif
